// File: compile.f
+incdir+hdl
hdl/intc_pkg.sv
hdl/imr_port.sv
hdl/irq_line.sv
hdl/service_sequencer.sv
hdl/intc_top.sv
verification/tb_intc.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator

set -u

cd "$(dirname "$0")" || { echo "Cannot enter the project root"; exit 1; }

BUILD_DIR=obj_dir
SIM_BIN=sim_intc
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_intc -f compile.f \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^No errors$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $LOG"
    exit 1
fi

// File: verification/tb_intc.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_defs.svh"

module tb_intc;

    localparam int NUM_TESTS  = 44;                    // Four directed tests plus 40 random rounds
    localparam int MAX_CYCLES = NUM_TESTS * 64 + 200;  // Hard stop for the run
    localparam int WAIT_LIMIT = 40;                    // Cycles allowed per handshake step

    logic                   clk;
    logic                   rst_n;
    logic [`INTC_LINES-1:0] io;
    logic                   imr_req;
    logic [`INTC_LINES-1:0] imr_data;
    logic                   int_ack;
    logic                   eoi;
    logic                   imr_ack;
    logic                   int_req;
    logic [31:0]            int_instr;

    logic [`INTC_LINES-1:0] model_pend;  // Latched edges whatever the mask
    logic [`INTC_LINES-1:0] model_mask;  // 1 enables the line
    logic [`INTC_LINES-1:0] model_isr;   // Lines whose handler runs

    int   errors;
    int   offers;        // Offers checked so far
    int   offered_line;  // Model line of the latest offer or -1 when none was eligible
    int   dut_line;      // Line decoded from the DUT vector at the latest offer
    int   cycles;
    int   sel;
    logic req_seen;      // int_req at the previous falling edge

    intc_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .io        (io),
        .imr_req   (imr_req),
        .imr_data  (imr_data),
        .int_ack   (int_ack),
        .eoi       (eoi),
        .imr_ack   (imr_ack),
        .int_req   (int_req),
        .int_instr (int_instr)
    );

    always #2 clk = ~clk;  // 4 ns period

    // Lowest unmasked pending line with no handler at equal or higher priority
    function automatic int select_line(input logic [`INTC_LINES-1:0] pend,
                                       input logic [`INTC_LINES-1:0] msk,
                                       input logic [`INTC_LINES-1:0] isr);
        for (int i = 0; i < `INTC_LINES; i++) begin
            if (isr[i]) begin
                return -1;  // This line and all below must wait
            end
            if (pend[i] && msk[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Trap word for the selected line
    function automatic logic [31:0] expected_instr(input logic [`INTC_LINES-1:0] pend,
                                                   input logic [`INTC_LINES-1:0] msk,
                                                   input logic [`INTC_LINES-1:0] isr);
        int         line;
        logic [7:0] vector;
        line   = select_line(pend, msk, isr);
        vector = `INTC_VECTOR_BASE + line[7:0];
        return {`INTC_TRAP_OPCODE, 16'h0000, vector};  // Opcode then zero field then vector
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns %s: got %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic report_stall(input string what);
        $display("Handshake failed at %0t ns: %s", $time, what);
        errors++;
    endtask

    // Drive point sits just after the rising edge
    task automatic next_drive();
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_drive();
    endtask

    task automatic pulse_lines(input logic [`INTC_LINES-1:0] lines);
        next_drive();
        io         = lines;
        model_pend = model_pend | lines;  // Edge latches whatever the mask
        idle_cycles(2);
        io = '0;
        idle_cycles(3);  // Edge has reached the pending bit
    endtask

    task automatic write_mask(input logic [`INTC_LINES-1:0] value);
        int waited;
        next_drive();
        imr_data   = value;
        imr_req    = 1'b1;
        model_mask = value;
        waited     = 0;
        while (!imr_ack && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!imr_ack) begin
            report_stall("imr_ack never rose after imr_req");
        end else begin
            check_value(32'(waited - 1), 32'd2, "imr_ack latency in cycles");
        end
        next_drive();
        imr_req = 1'b0;
        waited  = 0;
        while (imr_ack && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (imr_ack) begin
            report_stall("imr_ack stayed high after imr_req fell");
        end
    endtask

    // CPU takes the open offer after some delay
    task automatic ack_interrupt(input int delay);
        int          waited;
        logic [31:0] held;
        waited = 0;
        while (!int_req && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!int_req) begin
            report_stall("int_req never rose for an eligible line");
            return;
        end
        held = int_instr;
        idle_cycles(delay);
        next_drive();
        check_value(int_instr, held, "int_instr held during the offer");
        int_ack = 1'b1;
        waited  = 0;
        while (int_req && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (int_req) begin
            report_stall("int_req stayed high after int_ack");
        end else begin
            check_value(32'(waited - 1), 32'd1, "int_req fall after int_ack in cycles");
            if (offered_line >= 0) begin
                model_pend[offered_line] = 1'b0;  // Grant moves the line to service
                model_isr[offered_line]  = 1'b1;
            end
        end
        next_drive();
        int_ack = 1'b0;
        idle_cycles(2);  // FSM back to idle after seeing ack low
    endtask

    task automatic send_eoi();
        logic found;
        found = 1'b0;
        next_drive();
        eoi = 1'b1;
        for (int i = 0; i < `INTC_LINES; i++) begin
            if (model_isr[i] && !found) begin
                model_isr[i] = 1'b0;  // Highest priority handler ends
                found        = 1'b1;
            end
        end
        next_drive();
        eoi = 1'b0;
        idle_cycles(1);
    endtask

    // Acknowledge until the model has nothing eligible left
    task automatic serve_all(input int max_delay);
        for (int n = 0; n < 2 * `INTC_LINES; n++) begin
            if (select_line(model_pend, model_mask, model_isr) < 0) begin
                break;
            end
            ack_interrupt($urandom % (max_delay + 1));
        end
    endtask

    // Compare each new offer with the reference
    always @(negedge clk) begin
        if (rst_n && int_req && !req_seen) begin
            offers++;
            dut_line = int'(int_instr[7:0]) - int'(`INTC_VECTOR_BASE);
            sel      = select_line(model_pend, model_mask, model_isr);
            if (sel < 0) begin
                $display("Offer at %0t ns with no eligible line in the model", $time);
                errors++;
                offered_line = -1;
            end else begin
                offered_line = sel;
                check_value(int_instr, expected_instr(model_pend, model_mask, model_isr),
                            "int_instr on new offer");
            end
        end
        req_seen = int_req;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Run stopped after %0d cycles, tests did not finish", MAX_CYCLES);
            $display("Errors: %0d, offers checked: %0d", errors + 1, offers);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [`INTC_LINES-1:0] lines;
        int                     order [4];
        void'($urandom(32'hcf7b));
        order        = '{1, 2, 5, 7};  // Service order for the burst test
        clk          = 1'b0;
        rst_n        = 1'b0;
        io           = '0;
        imr_req      = 1'b0;
        imr_data     = '0;
        int_ack      = 1'b0;
        eoi          = 1'b0;
        model_pend   = '0;
        model_mask   = '1;  // All lines enabled out of reset
        model_isr    = '0;
        errors       = 0;
        offers       = 0;
        offered_line = -1;
        dut_line     = -1;
        cycles       = 0;
        req_seen     = 1'b0;
        repeat (3) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        idle_cycles(2);

        // One line at a time
        check_value(32'(int_req), 32'd0, "int_req after reset");
        check_value(32'(imr_ack), 32'd0, "imr_ack after reset");
        for (int i = 0; i < `INTC_LINES; i++) begin
            pulse_lines(8'b1 << i);
            ack_interrupt(1);
            check_value(32'(dut_line), 32'(i), "single line served");
            send_eoi();
        end

        // Burst on four lines served in index order
        pulse_lines(8'b1010_0110);
        for (int k = 0; k < 4; k++) begin
            ack_interrupt(2);
            check_value(32'(dut_line), 32'(order[k]), "burst service order");
            send_eoi();
        end

        // Line 6 waits behind line 5 while line 2 preempts
        pulse_lines(8'h20);
        ack_interrupt(0);
        check_value(32'(dut_line), 32'd5, "line 5 served");
        pulse_lines(8'h40);
        idle_cycles(6);
        check_value(32'(int_req), 32'd0, "line 6 held while line 5 in service");
        pulse_lines(8'h04);
        ack_interrupt(0);
        check_value(32'(dut_line), 32'd2, "line 2 nested above line 5");
        send_eoi();  // Ends line 2
        idle_cycles(4);
        check_value(32'(int_req), 32'd0, "line 6 held after first EOI");
        send_eoi();  // Ends line 5
        ack_interrupt(0);
        check_value(32'(dut_line), 32'd6, "line 6 after line 5 ends");
        send_eoi();

        // Masked line holds its request until unmasked
        write_mask(8'hf7);
        pulse_lines(8'h08);
        idle_cycles(6);
        check_value(32'(int_req), 32'd0, "masked line 3 not offered");
        write_mask(8'hff);
        ack_interrupt(0);
        check_value(32'(dut_line), 32'd3, "line 3 after unmask");
        send_eoi();

        for (int r = 0; r < 40; r++) begin
            if ($urandom % 4 == 0) begin
                write_mask(8'($urandom | $urandom));  // Mostly enabled
            end
            lines = 8'b1 << ($urandom % 8);
            if ($urandom % 2 == 1) begin
                lines = lines | (8'b1 << ($urandom % 8));
            end
            pulse_lines(lines);
            serve_all(6);
            if ($urandom % 3 != 0) begin
                send_eoi();
                serve_all(6);
            end
        end

        idle_cycles(4);
        $display("Errors: %0d, offers checked: %0d", errors, offers);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/intc_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_defs.svh"

module intc_top
    import intc_pkg::*;
(
    input  wire                   clk,        // System clock
    input  wire                   rst_n,      // Async reset, active low
    input  wire [`INTC_LINES-1:0] io,         // IO device requests
    input  wire                   imr_req,    // CPU mask write request
    input  wire [`INTC_LINES-1:0] imr_data,   // New mask value
    input  wire                   int_ack,    // CPU interrupt acknowledge
    input  wire                   eoi,        // End of interrupt pulse
    output logic                  imr_ack,    // Mask write accepted
    output logic                  int_req,    // Interrupt request to the CPU
    output logic [31:0]           int_instr   // Trap instruction as a raw word
);

    logic [`INTC_LINES-1:0] mask;        // IMR bits per slice
    logic [`INTC_LINES-1:0] io_sync;     // Synchronized IO per slice
    logic [`INTC_LINES-1:0] pending;     // Unmasked IRR bits
    logic [`INTC_LINES-1:0] in_service;  // ISR bits
    logic [`INTC_LINES-1:0] grant;       // Sequencer to slices
    logic [`INTC_LINES-1:0] eoi_clear;   // Sequencer to slices

    imr_port u_imr_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .io       (io),
        .imr_req  (imr_req),
        .imr_data (imr_data),
        .imr_ack  (imr_ack),
        .mask     (mask),
        .io_sync  (io_sync)
    );

    for (genvar i = 0; i < `INTC_LINES; i++) begin : g_line
        irq_line #(
            .LINE_ID (intc_line_t'(i))
        ) u_irq_line (
            .clk        (clk),
            .rst_n      (rst_n),
            .io_sync    (io_sync[i]),
            .mask       (mask[i]),
            .grant      (grant[i]),
            .eoi_clear  (eoi_clear[i]),
            .pending    (pending[i]),
            .in_service (in_service[i])
        );
    end

    service_sequencer u_service_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .pending    (pending),
        .in_service (in_service),
        .int_ack    (int_ack),
        .eoi        (eoi),
        .int_req    (int_req),
        .int_instr  (int_instr),  // Union seen as a plain word here
        .grant      (grant),
        .eoi_clear  (eoi_clear)
    );

endmodule

`default_nettype wire

// File: hdl/service_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_defs.svh"

module service_sequencer
    import intc_pkg::*;
(
    input  wire                    clk,         // System clock
    input  wire                    rst_n,       // Async reset, active low
    input  wire [`INTC_LINES-1:0]  pending,     // Unmasked pending bits from the slices
    input  wire [`INTC_LINES-1:0]  in_service,  // In-service bits from the slices
    input  wire                    int_ack,     // CPU acknowledge, four-phase
    input  wire                    eoi,         // Non-specific EOI pulse
    output logic                   int_req,     // Interrupt request to the CPU
    output intc_instr_u            int_instr,   // Trap instruction for the winner
    output logic [`INTC_LINES-1:0] grant,       // One-cycle one-hot grant
    output logic [`INTC_LINES-1:0] eoi_clear    // One-hot in-service clear
);

    localparam logic [1:0] ST_IDLE  = 2'd0;  // Nothing offered
    localparam logic [1:0] ST_OFFER = 2'd1;  // int_req high, waiting for ack
    localparam logic [1:0] ST_WAIT  = 2'd2;  // Granted, waiting for ack low

    logic [1:0]             state;
    logic                   win_valid;  // Some line is eligible
    intc_line_t             win_idx;    // Lowest eligible line
    intc_line_t             win_q;      // Winner latched at offer time
    intc_instr_u            instr_d;    // Instruction for the live winner
    logic [`INTC_LINES-1:0] isr_low;    // Lowest in-service bit, one-hot

    // Nested priority, scan from line 0 and stop at the first in-service line
    always_comb begin
        logic blocked;
        blocked   = 1'b0;
        win_valid = 1'b0;
        win_idx   = '0;
        for (int i = 0; i < `INTC_LINES; i++) begin
            if (in_service[i]) begin
                blocked = 1'b1;  // Equal and lower lines must wait
            end else if (pending[i] && !blocked && !win_valid) begin
                win_valid = 1'b1;
                win_idx   = intc_line_t'(i);
            end
        end
    end

    // Build the trap word from its fields
    always_comb begin
        instr_d.fields.opcode   = `INTC_TRAP_OPCODE;
        instr_d.fields.reserved = '0;
        instr_d.fields.vector   = `INTC_VECTOR_BASE + 8'(win_idx);
    end

    // Handshake FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            int_req <= 1'b0;
            grant   <= '0;
        end else begin
            grant <= '0;  // Pulse only
            case (state)
                ST_IDLE: begin
                    if (win_valid) begin
                        int_req <= 1'b1;
                        state   <= ST_OFFER;
                    end
                end
                ST_OFFER: begin
                    if (int_ack) begin
                        int_req        <= 1'b0;  // Drop together with the grant
                        grant[win_q]   <= 1'b1;
                        state          <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (!int_ack) begin
                        state <= ST_IDLE;  // Slices have updated by now
                    end
                end
                default: begin
                    state   <= ST_IDLE;
                    int_req <= 1'b0;
                end
            endcase
        end
    end

    // Winner and word frozen for the whole offer
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && win_valid) begin
            win_q     <= win_idx;
            int_instr <= instr_d;
        end
    end

    // EOI ends the highest priority handler
    assign isr_low   = in_service & (~in_service + 1'b1);
    assign eoi_clear = eoi ? isr_low : '0;

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant)
    ) else $error("grant is not one-hot");

    // Offer is never withdrawn or changed before the CPU acks
    a_instr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        int_req && $past(int_req) |-> $stable(int_instr.raw)
    ) else $error("int_instr changed while int_req was high");

endmodule

`default_nettype wire

// File: hdl/irq_line.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_defs.svh"

module irq_line
    import intc_pkg::*;
#(
    parameter intc_line_t LINE_ID = '0  // Position of this slice, for messages
) (
    input  wire  clk,         // System clock
    input  wire  rst_n,       // Async reset, active low
    input  wire  io_sync,     // Synchronized IO level
    input  wire  mask,        // 1 lets the request through
    input  wire  grant,       // CPU took this line
    input  wire  eoi_clear,   // End of this line's service
    output logic pending,     // Unmasked pending request
    output logic in_service   // Handler for this line is running
);

    logic level_q;  // io_sync one cycle ago
    logic pend_q;   // IRR bit, independent of mask
    logic rise;     // Rising edge this cycle

    assign rise = io_sync && !level_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q    <= 1'b0;
            pend_q     <= 1'b0;
            in_service <= 1'b0;
        end else begin
            level_q    <= io_sync;
            pend_q     <= rise || (pend_q && !grant);  // Repeat edges merge, new edge wins over grant
            in_service <= grant || (in_service && !eoi_clear);
        end
    end

    // Masked requests stay held in pend_q but are hidden here
    assign pending = pend_q && mask;

    // Sequencer may only grant what this slice offered
    a_grant_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        grant |-> pending
    ) else $error("line %0d granted without an unmasked pending request", LINE_ID);

endmodule

`default_nettype wire

// File: hdl/imr_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "intc_defs.svh"

module imr_port (
    input  wire                    clk,       // System clock
    input  wire                    rst_n,     // Async reset, active low
    input  wire [`INTC_LINES-1:0]  io,        // Raw IO requests, asynchronous
    input  wire                    imr_req,   // CPU mask write request
    input  wire [`INTC_LINES-1:0]  imr_data,  // New mask, stable while imr_req high
    output logic                   imr_ack,   // Write accepted
    output logic [`INTC_LINES-1:0] mask,      // 1 enables the line
    output logic [`INTC_LINES-1:0] io_sync    // IO after the synchronizer
);

    logic [`INTC_LINES-1:0] sync_q [`INTC_SYNC_STAGES];  // Synchronizer chain, stage 0 first
    logic                   wr_taken;                    // Mask copied for this request

    // Mask register and four-phase write state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mask     <= '1;  // All lines enabled
            wr_taken <= 1'b0;
            imr_ack  <= 1'b0;
        end else begin
            if (imr_req && !imr_ack && !wr_taken) begin
                mask     <= imr_data;  // First cycle of a fresh request
                wr_taken <= 1'b1;
            end else if (!imr_req) begin
                wr_taken <= 1'b0;  // Request gone, ready for the next one
            end
            imr_ack <= imr_req && wr_taken;  // Ack one edge after the copy, drop with req
        end
    end

    // Async IO lines into the clock domain
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `INTC_SYNC_STAGES; s++) begin
                sync_q[s] <= '0;  // Low so no false edge after reset
            end
        end else begin
            sync_q[0] <= io;
            for (int s = 1; s < `INTC_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];  // Shift toward the output
            end
        end
    end

    assign io_sync = sync_q[`INTC_SYNC_STAGES-1];  // Last stage feeds the slices

    // CPU must hold the mask word until the controller has acked
    a_imr_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        imr_req && $past(imr_req) && !imr_ack |-> $stable(imr_data)
    ) else $error("imr_data changed during an open mask write");

endmodule

`default_nettype wire

// File: hdl/intc_pkg.sv
`default_nettype none

package intc_pkg;

    `include "intc_defs.svh"

    // Index of one interrupt line
    typedef logic [$clog2(`INTC_LINES)-1:0] intc_line_t;

    // Trap instruction as the controller builds it
    typedef struct packed {
        logic [7:0]  opcode;    // Trap opcode, top byte
        logic [15:0] reserved;  // Always zero
        logic [7:0]  vector;    // Base plus line index
    } intc_instr_fields_t;

    // The CPU sees a raw word, the sequencer fills in fields
    typedef union packed {
        logic [31:0]        raw;     // Word as injected into the pipeline
        intc_instr_fields_t fields;  // Decoded trap layout
    } intc_instr_u;

endpackage

`default_nettype wire

// File: hdl/intc_defs.svh
`ifndef INTC_DEFS_SVH
`define INTC_DEFS_SVH

// Number of IO interrupt lines, line 0 is the highest priority
`define INTC_LINES 8

// Flop depth of the IO input synchronizer
`define INTC_SYNC_STAGES 2

// Top byte of the injected trap instruction
`define INTC_TRAP_OPCODE 8'hf0

// Vector for line n is this base plus n
`define INTC_VECTOR_BASE 8'h20

`endif
